// ==== project.f ====
logic/tile_pkg.sv
logic/ifill_adapter.sv
logic/pmu_event_unit.sv
logic/hpm_counters.sv
logic/tile_top.sv
bench/tile_props.sv
bench/tile_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the tile testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module tile_tb \
    -Mdir "$BUILD_DIR" \
    -o tile_sim \
    -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tile_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== bench/tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_tb
    import tile_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;

    // Cycle budget per test summed for the watchdog
    localparam int RESET_CYCLES  = 4;
    localparam int ACQ_CYCLES    = 4;
    localparam int LINE_CYCLES   = 16;
    localparam int RW_CYCLES     = 2 * NUM_HPM + 4;
    localparam int EVENT_CYCLES  = 3 * NUM_HPM + 12;
    localparam int REFILL_CYCLES = 3 * NUM_HPM + 16;
    localparam int ADDR_CYCLES   = 4;
    localparam int MARGIN_CYCLES = 40;
    localparam int TIMEOUT_NS    = CLK_PERIOD * (RESET_CYCLES + ACQ_CYCLES + LINE_CYCLES
                                   + RW_CYCLES + EVENT_CYCLES + REFILL_CYCLES
                                   + ADDR_CYCLES + MARGIN_CYCLES);

    logic                       CLK;
    logic                       RST;
    ifill_req_t                 ifill_req;
    l2_grant_t                  grant;
    pmu_raw_t                   pmu_raw;
    logic [DMEM_ADDR_WIDTH-1:0] dmem_addr;
    hpm_access_t                hpm_access;
    l2_acquire_t                acquire_o;
    logic                       grant_ready_o;
    ifill_resp_t                ifill_resp_o;
    logic [XLEN-1:0]            hpm_rdata_o;
    logic [XLEN-1:0]            last_dmem_addr_o;

    integer seed;
    int     checks;
    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;

    tile_top tile_top_inst (
        .CLK              (CLK),
        .RST              (RST),
        .ifill_req_i      (ifill_req),
        .grant_i          (grant),
        .pmu_raw_i        (pmu_raw),
        .dmem_addr_i      (dmem_addr),
        .hpm_access_i     (hpm_access),
        .acquire_o        (acquire_o),
        .grant_ready_o    (grant_ready_o),
        .ifill_resp_o     (ifill_resp_o),
        .hpm_rdata_o      (hpm_rdata_o),
        .last_dmem_addr_o (last_dmem_addr_o)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;  // Inputs change just after the edge
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    function automatic logic [CSR_ADDR_SIZE-1:0] hpm_addr(input int k);
        return HPM_BASE_ADDR + CSR_ADDR_SIZE'(k);
    endfunction

    function automatic logic [BEAT_WIDTH-1:0] random_beat();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_resp(input ifill_resp_t got, input ifill_resp_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s: line_valid %b exp %b, ack %b exp %b, line %s",
                     $time, msg, got.line_valid, exp.line_valid, got.ack, exp.ack,
                     (got.line === exp.line) ? "matches" : "differs");
        end
    endtask

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_acquire(input l2_acquire_t got, input l2_acquire_t exp,
                                 input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Bus sequences
    // --------------------------------------------------
    task automatic write_counter(input int k, input logic [XLEN-1:0] value);
        hpm_access.addr  = hpm_addr(k);
        hpm_access.we    = 1'b1;
        hpm_access.wdata = value;
        next_cycle();
        hpm_access.we = 1'b0;
    endtask

    task automatic read_counter(input logic [CSR_ADDR_SIZE-1:0] addr,
                                input logic [XLEN-1:0] exp, input string msg);
        hpm_access.addr = addr;
        hpm_access.we   = 1'b0;
        #1;
        check_data(hpm_rdata_o, exp, msg);
        next_cycle();
    endtask

    task automatic clear_counters();
        for (int k = 0; k < NUM_HPM; k++) write_counter(k, '0);
    endtask

    // order[i] is the beat index sent in the i-th grant
    task automatic run_refill(input logic [BEATS_PER_LINE-1:0][BEAT_IDX_WIDTH-1:0] order,
                              input logic hit, input string tag);
        logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0] beats;
        logic [BEAT_WIDTH-1:0]                     data;
        ifill_resp_t                               exp;
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            data            = random_beat();
            beats[order[i]] = data;
            grant.valid     = 1'b1;
            grant.beat      = order[i];
            grant.data      = data;
            pmu_raw.l2_hit  = hit;
            next_cycle();
            if (i < BEATS_PER_LINE - 1) begin
                check_data(XLEN'({ifill_resp_o.line_valid, ifill_resp_o.ack}), '0,
                           {tag, " no pulse before the last beat"});
            end
        end
        grant          = '0;
        pmu_raw.l2_hit = 1'b0;
        exp.line_valid = 1'b1;
        exp.line       = beats;  // Slot b holds beat b
        exp.ack        = 1'b1;
        check_resp(ifill_resp_o, exp, {tag, " completion"});
        next_cycle();
        exp.line_valid = 1'b0;
        exp.ack        = 1'b0;
        check_resp(ifill_resp_o, exp, {tag, " pulse ended"});
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_acquire();
        l2_acquire_t                exp;
        logic [BLOCK_ADDR_SIZE-1:0] addr;
        start_test();
        addr      = BLOCK_ADDR_SIZE'({$random(seed), $random(seed)});
        ifill_req = '{valid: 1'b1, block_addr: addr};
        #1;
        exp            = '0;
        exp.valid      = 1'b1;
        exp.addr_block = addr;
        exp.builtin    = ACQ_BUILTIN;
        exp.a_type     = ACQ_A_TYPE;
        exp.acq_union  = ACQ_UNION;
        check_acquire(acquire_o, exp, "acquire with request");
        check_data(XLEN'(grant_ready_o), XLEN'(1), "grant_ready_o held high");
        next_cycle();
        ifill_req = '0;
        #1;
        exp.valid      = 1'b0;
        exp.addr_block = '0;
        check_acquire(acquire_o, exp, "acquire without request");
        next_cycle();
        finish_test("acquire fields");
    endtask

    task automatic test_line();
        start_test();
        run_refill({2'd3, 2'd2, 2'd1, 2'd0}, 1'b0, "in order refill");
        run_refill({2'd3, 2'd0, 2'd2, 2'd1}, 1'b0, "out of order refill");
        idle(2);
        finish_test("line assembly");
    endtask

    task automatic test_counter_rw();
        logic [XLEN-1:0] value;
        start_test();
        for (int k = 0; k < NUM_HPM; k++) begin
            value = {$random(seed), $random(seed)};
            write_counter(k, value);
            read_counter(hpm_addr(k), value, $sformatf("counter %0d readback", k));
        end
        read_counter(HPM_BASE_ADDR - 12'd1, '0, "address below the bank");
        read_counter(hpm_addr(NUM_HPM), '0, "address above the bank");
        read_counter(12'h000, '0, "address zero");
        finish_test("counter write and read");
    endtask

    task automatic test_events();
        logic [XLEN-1:0] exp_cnt [NUM_HPM];
        start_test();
        for (int k = 0; k < NUM_HPM; k++) exp_cnt[k] = '0;
        exp_cnt[EV_ICACHE_REQ]   = 64'd5;
        exp_cnt[EV_ICACHE_KILL]  = 64'd3;
        exp_cnt[EV_DMEM_LOAD]    = 64'd4;
        exp_cnt[EV_DMEM_STORE]   = 64'd2;
        exp_cnt[EV_ITLB_ACCESS]  = 64'd6;
        exp_cnt[EV_ITLB_MISS_CY] = 64'd3;  // Fourth miss sees ready high
        clear_counters();
        for (int i = 0; i < 8; i++) begin
            pmu_raw.icache_req  = (i < 5);
            pmu_raw.icache_kill = (i < 3);
            pmu_raw.dmem_load   = (i < 4);
            pmu_raw.dmem_store  = (i < 2);
            pmu_raw.itlb_access = (i < 6);
            pmu_raw.itlb_miss   = (i < 4);
            pmu_raw.itlb_ready  = (i == 3);
            next_cycle();
        end
        pmu_raw = '0;
        idle(3);
        for (int k = 0; k < NUM_HPM; k++) begin
            read_counter(hpm_addr(k), exp_cnt[k], $sformatf("counter %0d after events", k));
        end
        finish_test("event counting");
    endtask

    task automatic test_refill_events();
        logic [XLEN-1:0] exp_cnt [NUM_HPM];
        start_test();
        for (int k = 0; k < NUM_HPM; k++) exp_cnt[k] = '0;
        exp_cnt[EV_REFILL_BEAT] = 64'd8;
        exp_cnt[EV_L2_HIT]      = 64'd1;
        clear_counters();
        run_refill({2'd3, 2'd2, 2'd1, 2'd0}, 1'b1, "refill with L2 hit");
        run_refill({2'd3, 2'd1, 2'd0, 2'd2}, 1'b0, "refill without L2 hit");
        idle(3);
        for (int k = 0; k < NUM_HPM; k++) begin
            read_counter(hpm_addr(k), exp_cnt[k], $sformatf("counter %0d after refills", k));
        end
        finish_test("refill events");
    endtask

    task automatic test_last_addr();
        logic [DMEM_ADDR_WIDTH-1:0] addr;
        start_test();
        addr                      = DMEM_ADDR_WIDTH'({$random(seed), $random(seed)});
        addr[DMEM_ADDR_WIDTH-1]   = 1'b1;  // Top bit set so the upper bits must stay zero
        dmem_addr                 = addr;
        next_cycle();
        check_data(last_dmem_addr_o, XLEN'(addr), "last dCache address");
        next_cycle();
        check_data(last_dmem_addr_o, XLEN'(addr), "last dCache address held");
        finish_test("last address");
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        seed         = 32'ha0c6_e2e9;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        RST          = 1'b0;
        ifill_req    = '0;
        grant        = '0;
        pmu_raw      = '0;
        dmem_addr    = '0;
        hpm_access   = '0;
        repeat (2) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b1;
        next_cycle();
        test_acquire();
        test_line();
        test_counter_rw();
        test_events();
        test_refill_events();
        test_last_addr();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tile_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_props
    import tile_pkg::*;
(
    input logic               CLK,
    input logic               RST,
    input hpm_access_t        hpm_access_i,
    input logic [NUM_HPM-1:0] events_i,
    input logic [XLEN-1:0]    hpm_rdata_i
);

    logic [CSR_ADDR_SIZE-1:0] offset;
    logic                     mapped;
    logic [HPM_IDX_WIDTH-1:0] idx;

    assign offset = hpm_access_i.addr - HPM_BASE_ADDR;
    assign mapped = offset < CSR_ADDR_SIZE'(NUM_HPM);  // Inside the counter bank
    assign idx    = offset[HPM_IDX_WIDTH-1:0];

    a_write_readback: assert property (@(posedge CLK) disable iff (!RST)
        ($past(hpm_access_i.we) && $past(mapped) && !hpm_access_i.we && events_i == '0
         && hpm_access_i.addr == $past(hpm_access_i.addr))
        |-> hpm_rdata_i == $past(hpm_access_i.wdata))
        else $error("counter does not read back the value just written");

    // Held address sees its counter step by one per event
    a_event_increment: assert property (@(posedge CLK) disable iff (!RST)
        (mapped && !$past(hpm_access_i.we) && hpm_access_i.addr == $past(hpm_access_i.addr)
         && $past(events_i[idx]))
        |-> hpm_rdata_i == $past(hpm_rdata_i) + XLEN'(1))
        else $error("counter did not advance by one on its event");

    a_no_decrease: assert property (@(posedge CLK) disable iff (!RST)
        (mapped && !$past(hpm_access_i.we) && hpm_access_i.addr == $past(hpm_access_i.addr))
        |-> hpm_rdata_i >= $past(hpm_rdata_i))
        else $error("counter value went down without a write");

endmodule

// Observes the access port and the event strobes of the counter bank
bind hpm_counters tile_props tile_props_inst (
    .CLK          (CLK),
    .RST          (RST),
    .hpm_access_i (hpm_access_i),
    .events_i     (events_i),
    .hpm_rdata_i  (hpm_rdata_o)
);

`default_nettype wire

// ==== logic/tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_top
    import tile_pkg::*;
(
    input  logic                       CLK,
    input  logic                       RST,

    input  ifill_req_t                 ifill_req_i,
    input  l2_grant_t                  grant_i,
    input  pmu_raw_t                   pmu_raw_i,
    input  logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_i,
    input  hpm_access_t                hpm_access_i,

    output l2_acquire_t                acquire_o,
    output logic                       grant_ready_o,
    output ifill_resp_t                ifill_resp_o,
    output logic [XLEN-1:0]            hpm_rdata_o,
    output logic [XLEN-1:0]            last_dmem_addr_o
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    logic               grant_ack;   // Last refill beat
    logic               grant_beat;  // Any refill beat
    logic [NUM_HPM-1:0] events;

    ifill_adapter ifill_adapter_inst (
        .CLK           (CLK),
        .RST           (RST),
        .ifill_req_i   (ifill_req_i),
        .grant_i       (grant_i),
        .acquire_o     (acquire_o),
        .grant_ready_o (grant_ready_o),
        .ifill_resp_o  (ifill_resp_o),
        .grant_ack_o   (grant_ack),
        .grant_beat_o  (grant_beat)
    );

    pmu_event_unit pmu_event_unit_inst (
        .CLK              (CLK),
        .RST              (RST),
        .pmu_raw_i        (pmu_raw_i),
        .grant_ack_i      (grant_ack),
        .grant_beat_i     (grant_beat),
        .dmem_addr_i      (dmem_addr_i),
        .events_o         (events),
        .last_dmem_addr_o (last_dmem_addr_o)
    );

    hpm_counters hpm_counters_inst (
        .CLK          (CLK),
        .RST          (RST),
        .events_i     (events),
        .hpm_access_i (hpm_access_i),
        .hpm_rdata_o  (hpm_rdata_o)
    );

endmodule

`default_nettype wire

// ==== logic/hpm_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module hpm_counters
    import tile_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,

    // One increment strobe per counter
    input  logic [NUM_HPM-1:0] events_i,

    // CSR style access port
    input  hpm_access_t        hpm_access_i,
    output logic [XLEN-1:0]    hpm_rdata_o
);

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    logic [CSR_ADDR_SIZE-1:0] addr_offset;
    logic                     addr_hit;
    logic [HPM_IDX_WIDTH-1:0] sel;
    logic [NUM_HPM-1:0]       wr_sel;

    // Below the base the subtraction wraps high and misses as well
    assign addr_offset = hpm_access_i.addr - HPM_BASE_ADDR;
    assign addr_hit    = addr_offset < CSR_ADDR_SIZE'(NUM_HPM);
    assign sel         = addr_offset[HPM_IDX_WIDTH-1:0];

    // One-hot write select
    always_comb begin
        wr_sel = '0;
        if (hpm_access_i.we && addr_hit) begin
            wr_sel[sel] = 1'b1;
        end
    end

    // --------------------------------------------------
    // Counter bank
    // --------------------------------------------------
    logic [NUM_HPM-1:0][XLEN-1:0] cnt_q;

    for (genvar g = 0; g < NUM_HPM; g++) begin : g_cnt
        always_ff @(posedge CLK, negedge RST) begin
            if (!RST) begin
                cnt_q[g] <= '0;
            end else if (wr_sel[g]) begin
                cnt_q[g] <= hpm_access_i.wdata;  // Write wins over the event
            end else if (events_i[g]) begin
                cnt_q[g] <= cnt_q[g] + XLEN'(1);
            end
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    // Unmapped addresses read as zero
    assign hpm_rdata_o = addr_hit ? cnt_q[sel] : '0;

endmodule

`default_nettype wire

// ==== logic/pmu_event_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmu_event_unit
    import tile_pkg::*;
(
    input  logic                       CLK,
    input  logic                       RST,

    // Raw strobes from the tile
    input  pmu_raw_t                   pmu_raw_i,

    // Refill pulses from the refill bridge
    input  logic                       grant_ack_i,
    input  logic                       grant_beat_i,

    // dCache miss-read address
    input  logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_i,

    output logic [NUM_HPM-1:0]         events_o,
    output logic [XLEN-1:0]            last_dmem_addr_o
);

    logic [NUM_HPM-1:0]         events_d;
    logic [NUM_HPM-1:0]         events_q;
    logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_q;

    // --------------------------------------------------
    // Event formation
    // --------------------------------------------------
    always_comb begin
        events_d                  = '0;
        events_d[EV_ICACHE_REQ]   = pmu_raw_i.icache_req;
        events_d[EV_ICACHE_KILL]  = pmu_raw_i.icache_kill;
        events_d[EV_L2_HIT]       = grant_ack_i & pmu_raw_i.l2_hit;  // Refill served by L2
        events_d[EV_DMEM_LOAD]    = pmu_raw_i.dmem_load;
        events_d[EV_DMEM_STORE]   = pmu_raw_i.dmem_store;
        events_d[EV_ITLB_ACCESS]  = pmu_raw_i.itlb_access;
        // Count only cycles where the miss is still waiting on the walk
        events_d[EV_ITLB_MISS_CY] = pmu_raw_i.itlb_miss & ~pmu_raw_i.itlb_ready;
        events_d[EV_REFILL_BEAT]  = grant_beat_i;
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            events_q    <= '0;
            dmem_addr_q <= '0;
        end else begin
            events_q    <= events_d;
            dmem_addr_q <= dmem_addr_i;  // Sampled every cycle
        end
    end

    assign events_o = events_q;

    // Zero extended for the debug port
    assign last_dmem_addr_o = {{(XLEN-DMEM_ADDR_WIDTH){1'b0}}, dmem_addr_q};

endmodule

`default_nettype wire

// ==== logic/ifill_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifill_adapter
    import tile_pkg::*;
(
    input  logic        CLK,
    input  logic        RST,

    // Refill request from the instruction cache
    input  ifill_req_t  ifill_req_i,

    // Grant beats from L2
    input  l2_grant_t   grant_i,

    // Acquire towards L2
    output l2_acquire_t acquire_o,
    output logic        grant_ready_o,

    // Assembled line back to the instruction cache
    output ifill_resp_t ifill_resp_o,

    // Event pulses for the PMU
    output logic        grant_ack_o,
    output logic        grant_beat_o
);

    // --------------------------------------------------
    // Acquire channel
    // --------------------------------------------------
    // Request is passed straight through, the rest is fixed
    assign acquire_o.valid      = ifill_req_i.valid;
    assign acquire_o.addr_block = ifill_req_i.block_addr;
    assign acquire_o.xact_id    = 1'b0;
    assign acquire_o.addr_beat  = '0;
    assign acquire_o.data       = '0;
    assign acquire_o.builtin    = ACQ_BUILTIN;
    assign acquire_o.a_type     = ACQ_A_TYPE;
    assign acquire_o.acq_union  = ACQ_UNION;

    assign grant_ready_o = 1'b1;  // L2 is never stalled

    // --------------------------------------------------
    // Grant beat assembly
    // --------------------------------------------------
    logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0] line_q;  // Slot per beat index
    logic                                      last_beat;
    logic                                      done_q;

    localparam logic [BEAT_IDX_WIDTH-1:0] LAST_BEAT_IDX = BEAT_IDX_WIDTH'(BEATS_PER_LINE - 1);

    assign last_beat = grant_i.valid && (grant_i.beat == LAST_BEAT_IDX);

    // Each beat lands in the slot named by its index, order does not matter
    always_ff @(posedge CLK) begin
        if (grant_i.valid) begin
            line_q[grant_i.beat] <= grant_i.data;
        end
    end

    // One-cycle completion pulse after the last beat
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            done_q <= 1'b0;
        end else begin
            done_q <= last_beat;
        end
    end

    assign ifill_resp_o.line_valid = done_q;
    assign ifill_resp_o.line       = line_q;  // Beat 3 in the top slice
    assign ifill_resp_o.ack        = done_q;

    // --------------------------------------------------
    // PMU strobes
    // --------------------------------------------------
    // Same cycle as the grant, so the L2 hit flag lines up with it
    assign grant_ack_o  = last_beat;
    assign grant_beat_o = grant_i.valid;

endmodule

`default_nettype wire

// ==== logic/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int BLOCK_ADDR_SIZE = 34;
    localparam int BEAT_WIDTH      = 128;
    localparam int BEATS_PER_LINE  = 4;
    localparam int BEAT_IDX_WIDTH  = 2;
    localparam int LINE_WIDTH      = BEAT_WIDTH * BEATS_PER_LINE;
    localparam int DMEM_ADDR_WIDTH = 40;
    localparam int XLEN            = 64;
    localparam int CSR_ADDR_SIZE   = 12;

    // Counter bank
    localparam int NUM_HPM       = 8;
    localparam int HPM_IDX_WIDTH = 3;
    localparam logic [CSR_ADDR_SIZE-1:0] HPM_BASE_ADDR = 12'hB03; // mhpmcounter3

    // Fixed acquire fields for an instruction refill
    localparam logic [2:0]  ACQ_A_TYPE  = 3'b001;
    localparam logic [16:0] ACQ_UNION   = 17'b00000000111000001;
    localparam logic        ACQ_BUILTIN = 1'b1;

    // --------------------------------------------------
    // Bus structs
    // --------------------------------------------------
    typedef struct packed {
        logic                       valid;
        logic [BLOCK_ADDR_SIZE-1:0] block_addr;
    } ifill_req_t;

    typedef struct packed {
        logic                       valid;
        logic [BLOCK_ADDR_SIZE-1:0] addr_block;
        logic                       xact_id;
        logic [BEAT_IDX_WIDTH-1:0]  addr_beat;
        logic [BEAT_WIDTH-1:0]      data;
        logic                       builtin;
        logic [2:0]                 a_type;
        logic [16:0]                acq_union;
    } l2_acquire_t;

    typedef struct packed {
        logic                      valid;
        logic [BEAT_WIDTH-1:0]     data;
        logic [BEAT_IDX_WIDTH-1:0] beat;
    } l2_grant_t;

    typedef struct packed {
        logic                  line_valid;
        logic [LINE_WIDTH-1:0] line;
        logic                  ack;
    } ifill_resp_t;

    typedef struct packed {
        logic [CSR_ADDR_SIZE-1:0] addr;
        logic                     we;
        logic [XLEN-1:0]          wdata;
    } hpm_access_t;

    typedef struct packed {
        logic icache_req;
        logic icache_kill;
        logic l2_hit;
        logic dmem_load;
        logic dmem_store;
        logic itlb_access;
        logic itlb_miss;
        logic itlb_ready;
    } pmu_raw_t;

    // Event index of each counter
    typedef enum logic [HPM_IDX_WIDTH-1:0] {
        EV_ICACHE_REQ   = 3'd0,
        EV_ICACHE_KILL  = 3'd1,
        EV_L2_HIT       = 3'd2,
        EV_DMEM_LOAD    = 3'd3,
        EV_DMEM_STORE   = 3'd4,
        EV_ITLB_ACCESS  = 3'd5,
        EV_ITLB_MISS_CY = 3'd6,
        EV_REFILL_BEAT  = 3'd7
    } hpm_event_e;

endpackage

`default_nettype wire
